// File: list.f
common/memSwitchPkg.sv
request/requestMux.sv
return/responseQueue.sv
return/returnMerge.sv
src/memSwitch.sv
bench/memSwitch_assert.sv
bench/tbMemSwitch.sv

// File: Bender.yml
package:
  name: mem_switch

sources:
  - common/memSwitchPkg.sv
  - request/requestMux.sv
  - return/responseQueue.sv
  - return/returnMerge.sv
  - src/memSwitch.sv
  - target: test
    files:
      - bench/memSwitch_assert.sv
      - bench/tbMemSwitch.sv

// File: bench/tbMemSwitch.sv
`default_nettype none

module tbMemSwitch import memSwitchPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int numRequests = 300;
	// six cycles per request covers the slowest target plus some drain
	localparam int timeoutCycles = numRequests * 6 + 200;

	logic CLK;
	logic RESETn;
	logic [numChannels-1:0] LACT;
	logic [numChannels-1:0] LCMD;
	logic [numChannels-1:0] LNEXT;
	logic [numChannels-1:0] LDRDY;
	logic [1:0] LSIZEO [numChannels-1:0];
	logic [addrWidth-1:0] LADDR [numChannels-1:0];
	logic [dataWidth-1:0] LDATO [numChannels-1:0];
	logic [localTagWidth-1:0] LTAGO [numChannels-1:0];
	logic [dataWidth-1:0] LDATI;
	logic [localTagWidth-1:0] LTAGI;
	logic [2:0] LSIZEI;
	memCmd CMD;
	logic [addrWidth-1:0] ADDR;
	logic [dataWidth-1:0] DATA;
	logic [beWidth-1:0] BE;
	logic [tagWidth-1:0] TAG;

	// target models, 0 flash, 1 sdram, 2 io
	logic [2:0] tgtAct;
	logic [2:0] tgtNext;
	logic [2:0] tgtDrdy;
	logic [2:0] tgtBusy;
	logic [dataWidth-1:0] tgtDat [3];
	logic [tagWidth-1:0] tgtTag [3];
	logic [tagWidth-1:0] heldTag [3];
	int tgtDelay [3];

	logic [31:0] lfsrState;
	int issued;
	int respSent;
	int pulses;
	int cycles;
	int assertErrors;
	int timeoutErrors;

	memSwitch memSwitch_i (
		.CLK, .RESETn, .LNEXT, .LACT, .LCMD, .LSIZEO, .LADDR, .LDATO, .LTAGO,
		.LDRDY, .LDATI, .LTAGI, .LSIZEI, .CMD, .ADDR, .DATA, .BE, .TAG,
		.FLNEXT(tgtNext[0]), .FLDRDY(tgtDrdy[0]), .FLDAT(tgtDat[0]), .FLTAG(tgtTag[0]),
		.FLACT(tgtAct[0]),
		.SDNEXT(tgtNext[1]), .SDDRDY(tgtDrdy[1]), .SDDAT(tgtDat[1]), .SDTAG(tgtTag[1]),
		.SDACT(tgtAct[1]),
		.IONEXT(tgtNext[2]), .IODRDY(tgtDrdy[2]), .IODAT(tgtDat[2]), .IOTAG(tgtTag[2]),
		.IOACT(tgtAct[2])
	);

	bind memSwitch memSwitch_assert memSwitchChecks (
		.CLK, .RESETn, .LACT, .LCMD, .LNEXT, .LSIZEO, .LADDR, .LDATO, .LTAGO,
		.LDRDY, .LDATI, .LTAGI, .LSIZEI, .CMD, .ADDR, .DATA, .BE, .TAG,
		.FLACT, .SDACT, .IOACT, .FLNEXT, .SDNEXT, .IONEXT,
		.FLDRDY, .IODRDY, .SDDRDY, .SDDAT, .SDTAG, .flFill, .ioFill
	);

	task automatic countAssertFailure();
		assertErrors++;
	endtask

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [63:0] randomBits(input int n);
		logic [63:0] bits;
		logic feedback;
		bits = '0;
		for (int k = 0; k < n; k++) begin
			feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], feedback};
			bits = {bits[62:0], feedback};
		end
		return bits;
	endfunction

	function automatic logic [addrWidth-1:0] randomAddress();
		case (2'(randomBits(2)))
			2'd0: return addrWidth'(randomBits(30));
			2'd2: return ioBase + addrWidth'(randomBits(16));
			default: return flashLimit + addrWidth'(randomBits(32));
		endcase
	endfunction

	task automatic issueRequest(input int i);
		LACT[i] <= 1'b1;
		LCMD[i] <= 1'(randomBits(1));
		LSIZEO[i] <= 2'(randomBits(2));
		LADDR[i] <= randomAddress();
		LDATO[i] <= randomBits(64);
		LTAGO[i] <= localTagWidth'(randomBits(localTagWidth));
		issued++;
	endtask

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// ----------------------------------------------------------
	// requesters and target models
	// ----------------------------------------------------------
	always @(posedge CLK) begin
		if (RESETn) begin
			cycles++;
			respSent += $countones(tgtDrdy);
			pulses += $countones(LDRDY);
			for (int i = 0; i < numChannels; i++) begin
				if (LACT[i] && LNEXT[i]) begin
					LACT[i] <= 1'b0;
				end
				if ((!LACT[i] || LNEXT[i]) && issued < numRequests && randomBits(1)) begin
					issueRequest(i);
				end
			end
			for (int t = 0; t < 3; t++) begin
				tgtDrdy[t] <= 1'b0;
				if (tgtBusy[t]) begin
					if (tgtDelay[t] == 0) begin
						tgtDrdy[t] <= 1'b1;
						tgtDat[t] <= randomBits(64);
						tgtTag[t] <= heldTag[t];
						tgtBusy[t] = 1'b0;
					end else begin
						tgtDelay[t]--;
					end
				end else if (tgtAct[t] && tgtNext[t]) begin
					heldTag[t] = TAG;
					tgtDelay[t] = int'(randomBits(2));
					tgtBusy[t] = 1'b1;
					tgtNext[t] <= 1'b0;
				end else begin
					// ready three cycles in four
					tgtNext[t] <= |randomBits(2);
				end
			end
		end
	end

	initial begin
		lfsrState = 32'h888e;
		issued = 0;
		respSent = 0;
		pulses = 0;
		cycles = 0;
		assertErrors = 0;
		timeoutErrors = 0;
		RESETn = 1'b0;
		LACT = '0;
		LCMD = '0;
		tgtNext = '0;
		tgtDrdy = '0;
		tgtBusy = '0;
		for (int i = 0; i < 3; i++) begin
			LSIZEO[i] = '0;
			LADDR[i] = '0;
			LDATO[i] = '0;
			LTAGO[i] = '0;
			tgtDat[i] = '0;
			tgtTag[i] = '0;
			heldTag[i] = '0;
			tgtDelay[i] = 0;
		end
		repeat (8) @(posedge CLK);
		RESETn <= 1'b1;
		// queued responses drain after the last one is sent
		while ((respSent < numRequests || pulses < respSent) && cycles < timeoutCycles) begin
			@(posedge CLK);
		end
		if (cycles >= timeoutCycles) begin
			timeoutErrors++;
			$display("timeout after %0d cycles, %0d of %0d responses sent, %0d returned",
				cycles, respSent, numRequests, pulses);
		end
		// one more edge for the checks on the last return
		@(posedge CLK);
		returnCount: assert (pulses == respSent)
			else begin
				$error("Error return count: expected %0d, actual %0d", respSent, pulses);
				assertErrors++;
			end
		$display("assertion errors: %0d, timeout errors: %0d", assertErrors, timeoutErrors);
		if (assertErrors + timeoutErrors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/memSwitch_assert.sv
`default_nettype none

module memSwitch_assert import memSwitchPkg::*; (
	input wire CLK,
	input wire RESETn,
	input wire [numChannels-1:0] LACT,
	input wire [numChannels-1:0] LCMD,
	input wire [numChannels-1:0] LNEXT,
	input wire [1:0] LSIZEO [numChannels-1:0],
	input wire [addrWidth-1:0] LADDR [numChannels-1:0],
	input wire [dataWidth-1:0] LDATO [numChannels-1:0],
	input wire [localTagWidth-1:0] LTAGO [numChannels-1:0],
	input wire [numChannels-1:0] LDRDY,
	input wire [dataWidth-1:0] LDATI,
	input wire [localTagWidth-1:0] LTAGI,
	input wire [2:0] LSIZEI,
	input memCmd CMD,
	input wire [addrWidth-1:0] ADDR,
	input wire [dataWidth-1:0] DATA,
	input wire [beWidth-1:0] BE,
	input wire [tagWidth-1:0] TAG,
	input wire FLACT,
	input wire SDACT,
	input wire IOACT,
	input wire FLNEXT,
	input wire SDNEXT,
	input wire IONEXT,
	input wire FLDRDY,
	input wire IODRDY,
	input wire SDDRDY,
	input wire [dataWidth-1:0] SDDAT,
	input wire [tagWidth-1:0] SDTAG,
	input wire [countWidth-1:0] flFill,
	input wire [countWidth-1:0] ioFill
);

	logic accept;
	logic hold;
	logic [1:0] selIdx;
	logic [2:0] expRegion;
	logic [tagWidth-1:0] expTag;
	logic [tagWidth-1:0] expTagQ;
	logic [addrWidth-1:0] expAddrQ;
	logic expCmdQ;
	logic [beWidth-1:0] expBe;
	logic [beWidth-1:0] expBeQ;
	logic [dataWidth-1:0] expData;
	logic [dataWidth-1:0] expDataQ;
	logic [dataWidth-1:0] expAligned;
	logic [dataWidth-1:0] alignedQ [2];
	logic [tagWidth-1:0] sdTagQ [2];
	logic [numChannels-1:0] expRdy;
	logic [numChannels-1:0] rdyQ [2];

	assign accept = |(LACT & LNEXT);
	assign hold = (FLACT & ~FLNEXT) | (SDACT & ~SDNEXT) | (IOACT & ~IONEXT);
	assign expRegion = {expAddrQ >= ioBase, expAddrQ >= flashLimit && expAddrQ < ioBase,
		expAddrQ < flashLimit};

	// ----------------------------------------------------------
	// reference values from the lane and alignment rules
	// ----------------------------------------------------------
	always_comb begin
		int sz;
		int low;
		int base;
		selIdx = LACT[0] ? 2'd0 : (LACT[1] ? 2'd1 : 2'd2);
		expTag = {LADDR[selIdx][2:0], LSIZEO[selIdx],
			LACT[0] ? coreId : (LACT[1] ? streamId : contextId), LTAGO[selIdx]};
		sz = int'(LSIZEO[selIdx]);
		low = int'(LADDR[selIdx][2:0]);
		for (int b = 0; b < beWidth; b++) begin
			// lane is in use when it shares the aligned item with the address
			expBe[b] = !(sz == 3 || (b >> sz) == (low >> sz));
			expData[8*b +: 8] = LDATO[selIdx][8*(b % (1 << sz)) +: 8];
		end
		sz = int'(SDTAG[tagSizePos +: 2]);
		low = int'(SDTAG[tagLowAddrPos +: 3]);
		base = (low >> sz) << sz;
		for (int b = 0; b < beWidth; b++) begin
			expAligned[8*b +: 8] = (b < (1 << sz)) ? SDDAT[8*(base + b) +: 8] : 8'h00;
		end
		expRdy = {SDTAG[tagChanPos +: 3] == contextId, SDTAG[tagChanPos +: 3] == streamId,
			SDTAG[tagChanPos +: 3] == coreId};
	end

	always_ff @(posedge CLK) begin
		expTagQ <= expTag;
		expAddrQ <= LADDR[selIdx];
		expCmdQ <= LCMD[selIdx];
		expBeQ <= expBe;
		expDataQ <= expData;
		// two stages to line up with the sdram return path
		alignedQ[0] <= expAligned;
		alignedQ[1] <= alignedQ[0];
		sdTagQ[0] <= SDTAG;
		sdTagQ[1] <= sdTagQ[0];
		rdyQ[0] <= expRdy;
		rdyQ[1] <= rdyQ[0];
	end

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------
	tagAndPriority: assert property (@(posedge CLK) disable iff (!RESETn)
			accept |=> TAG == expTagQ && ADDR == expAddrQ)
		else begin
			$error("Error request tag: expected %h at %h, actual %h at %h",
				expTagQ, expAddrQ, TAG, ADDR);
			tbMemSwitch.countAssertFailure();
		end

	commandCapture: assert property (@(posedge CLK) disable iff (!RESETn)
			accept |=> CMD == expCmdQ)
		else begin
			$error("Error request command: expected %b, actual %b", expCmdQ, CMD);
			tbMemSwitch.countAssertFailure();
		end

	lanesAndData: assert property (@(posedge CLK) disable iff (!RESETn)
			accept |=> BE == expBeQ && DATA == expDataQ)
		else begin
			$error("Error lanes: expected BE %b DATA %h, actual BE %b DATA %h",
				expBeQ, expDataQ, BE, DATA);
			tbMemSwitch.countAssertFailure();
		end

	regionSelect: assert property (@(posedge CLK) disable iff (!RESETn)
			accept |=> {IOACT, SDACT, FLACT} == expRegion)
		else begin
			$error("Error region: expected io/sd/fl %b, actual %b",
				expRegion, {IOACT, SDACT, FLACT});
			tbMemSwitch.countAssertFailure();
		end

	stallNoNext: assert property (@(posedge CLK) disable iff (!RESETn) hold |-> LNEXT == '0)
		else begin
			$error("Error stall: expected LNEXT 000, actual %b", LNEXT);
			tbMemSwitch.countAssertFailure();
		end

	stallHolds: assert property (@(posedge CLK) disable iff (!RESETn)
			hold |=> $stable(ADDR) && $stable(TAG) && $stable(BE) && $stable(DATA)
				&& $stable({FLACT, SDACT, IOACT}))
		else begin
			$error("memory command changed while the target held it off");
			tbMemSwitch.countAssertFailure();
		end

	sdramReturn: assert property (@(posedge CLK) disable iff (!RESETn)
			SDDRDY |-> ##2 (LDRDY == rdyQ[1] && LTAGI == sdTagQ[1][localTagWidth-1:0]
				&& LSIZEI == {1'b0, sdTagQ[1][tagSizePos +: 2]} && LDATI == alignedQ[1]))
		else begin
			$error("Error sdram return: expected rdy %b data %h, actual rdy %b data %h",
				rdyQ[1], alignedQ[1], LDRDY, LDATI);
			tbMemSwitch.countAssertFailure();
		end

	queueRoom: assert property (@(posedge CLK) disable iff (!RESETn)
			!((FLDRDY && flFill == '1) || (IODRDY && ioFill == '1)))
		else begin
			$error("response written into a queue that shows full");
			tbMemSwitch.countAssertFailure();
		end

endmodule

`default_nettype wire

// File: src/memSwitch.sv
`default_nettype none

module memSwitch import memSwitchPkg::*; (
	input wire CLK,
	input wire RESETn,

	// local requesters
	output logic [numChannels-1:0] LNEXT,
	input wire [numChannels-1:0] LACT,
	input wire [numChannels-1:0] LCMD,
	input wire [1:0] LSIZEO [numChannels-1:0],
	input wire [addrWidth-1:0] LADDR [numChannels-1:0],
	input wire [dataWidth-1:0] LDATO [numChannels-1:0],
	input wire [localTagWidth-1:0] LTAGO [numChannels-1:0],
	output logic [numChannels-1:0] LDRDY,
	output logic [dataWidth-1:0] LDATI,
	output logic [localTagWidth-1:0] LTAGI,
	output logic [2:0] LSIZEI,

	// memory command port
	output memCmd CMD,
	output logic [addrWidth-1:0] ADDR,
	output logic [dataWidth-1:0] DATA,
	output logic [beWidth-1:0] BE,
	output logic [tagWidth-1:0] TAG,

	input wire FLNEXT,
	input wire FLDRDY,
	input wire [dataWidth-1:0] FLDAT,
	input wire [tagWidth-1:0] FLTAG,
	output logic FLACT,

	input wire SDNEXT,
	input wire SDDRDY,
	input wire [dataWidth-1:0] SDDAT,
	input wire [tagWidth-1:0] SDTAG,
	output logic SDACT,

	input wire IONEXT,
	input wire IODRDY,
	input wire [dataWidth-1:0] IODAT,
	input wire [tagWidth-1:0] IOTAG,
	output logic IOACT
);

	logic [respWidth-1:0] flHead;
	logic [respWidth-1:0] ioHead;
	logic flEmpty;
	logic ioEmpty;
	logic [countWidth-1:0] flFill;
	logic [countWidth-1:0] ioFill;
	logic flPop;
	logic ioPop;

	requestMux requestMux_i (
		.CLK(CLK), .RESETn(RESETn),
		.LACT(LACT), .LCMD(LCMD), .LSIZEO(LSIZEO), .LADDR(LADDR),
		.LDATO(LDATO), .LTAGO(LTAGO), .LNEXT(LNEXT),
		.FLNEXT(FLNEXT), .SDNEXT(SDNEXT), .IONEXT(IONEXT),
		.CMD(CMD), .ADDR(ADDR), .DATA(DATA), .BE(BE), .TAG(TAG),
		.FLACT(FLACT), .SDACT(SDACT), .IOACT(IOACT)
	);

	// slow sources are buffered, sdram goes straight to the merge
	responseQueue flQueue (
		.CLK(CLK), .RESETn(RESETn),
		.writeEn(FLDRDY), .writeData({FLTAG, FLDAT}), .popEn(flPop),
		.head(flHead), .empty(flEmpty), .fill(flFill)
	);

	responseQueue ioQueue (
		.CLK(CLK), .RESETn(RESETn),
		.writeEn(IODRDY), .writeData({IOTAG, IODAT}), .popEn(ioPop),
		.head(ioHead), .empty(ioEmpty), .fill(ioFill)
	);

	returnMerge returnMerge_i (
		.CLK(CLK), .RESETn(RESETn),
		.SDDRDY(SDDRDY), .SDDAT(SDDAT), .SDTAG(SDTAG),
		.flHead(flHead), .flEmpty(flEmpty), .flFill(flFill),
		.ioHead(ioHead), .ioEmpty(ioEmpty), .ioFill(ioFill),
		.flPop(flPop), .ioPop(ioPop),
		.LDRDY(LDRDY), .LDATI(LDATI), .LTAGI(LTAGI), .LSIZEI(LSIZEI)
	);

endmodule

`default_nettype wire

// File: return/returnMerge.sv
`default_nettype none

module returnMerge import memSwitchPkg::*; (
	input wire CLK,
	input wire RESETn,

	input wire SDDRDY,
	input wire [dataWidth-1:0] SDDAT,
	input wire [tagWidth-1:0] SDTAG,

	input wire [respWidth-1:0] flHead,
	input wire flEmpty,
	input wire [countWidth-1:0] flFill,
	input wire [respWidth-1:0] ioHead,
	input wire ioEmpty,
	input wire [countWidth-1:0] ioFill,
	output logic flPop,
	output logic ioPop,

	output logic [numChannels-1:0] LDRDY,
	output logic [dataWidth-1:0] LDATI,
	output logic [localTagWidth-1:0] LTAGI,
	output logic [2:0] LSIZEI
);

	logic pickIo;
	logic stageValid;
	logic [respWidth-1:0] stageEntry;
	logic [tagWidth-1:0] stageTag;
	logic [dataWidth-1:0] stageData;
	logic [1:0] size;
	logic [2:0] laneOffset;
	logic [dataWidth-1:0] shifted;

	// ----------------------------------------------------------
	// stage one, source select
	// ----------------------------------------------------------
	// fuller queue goes first, io on a tie
	assign pickIo = ioFill >= flFill;
	assign ioPop = ~SDDRDY & pickIo & ~ioEmpty;
	assign flPop = ~SDDRDY & ~pickIo & ~flEmpty;

	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			stageValid <= 1'b0;
		end else begin
			stageValid <= SDDRDY | ioPop | flPop;
		end
	end

	// sdram has no queue, so it always wins
	always_ff @(posedge CLK) begin
		if (SDDRDY) begin
			stageEntry <= {SDTAG, SDDAT};
		end else if (pickIo) begin
			stageEntry <= ioHead;
		end else begin
			stageEntry <= flHead;
		end
	end

	// ----------------------------------------------------------
	// stage two, route and align
	// ----------------------------------------------------------
	assign {stageTag, stageData} = stageEntry;
	assign size = stageTag[tagSizePos +: 2];

	// byte offset of the item inside the 64-bit word
	always_comb begin
		case (size)
			2'd0: laneOffset = stageTag[tagLowAddrPos +: 3];
			2'd1: laneOffset = {stageTag[tagLowAddrPos + 2], stageTag[tagLowAddrPos + 1], 1'b0};
			2'd2: laneOffset = {stageTag[tagLowAddrPos + 2], 2'b00};
			default: laneOffset = 3'd0;
		endcase
	end

	assign shifted = stageData >> {laneOffset, 3'b000};

	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			LDRDY <= '0;
		end else begin
			for (int i = 0; i < numChannels; i++) begin
				LDRDY[i] <= stageValid && (stageTag[tagChanPos +: 3] == chanIdOf(2'(i)));
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (stageValid) begin
			LTAGI <= stageTag[localTagWidth-1:0];
			LSIZEI <= {1'b0, size};
			case (size)
				2'd0: LDATI <= dataWidth'(shifted[7:0]);
				2'd1: LDATI <= dataWidth'(shifted[15:0]);
				2'd2: LDATI <= dataWidth'(shifted[31:0]);
				default: LDATI <= stageData;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: return/responseQueue.sv
`default_nettype none

module responseQueue import memSwitchPkg::*; (
	input wire CLK,
	input wire RESETn,
	input wire writeEn,
	input wire [respWidth-1:0] writeData,
	input wire popEn,
	output logic [respWidth-1:0] head,
	output logic empty,
	output logic [countWidth-1:0] fill
);

	logic [respWidth-1:0] entries [queueDepth];
	logic [countWidth-1:0] wrPtr;
	logic [countWidth-1:0] rdPtr;
	// one bit wider than fill so a full queue is visible
	logic [countWidth:0] count;
	logic full;
	logic doWrite;
	logic doPop;

	assign full = count == (countWidth + 1)'(queueDepth);
	assign empty = count == '0;
	assign doWrite = writeEn & ~full;
	assign doPop = popEn & ~empty;

	// show-ahead head entry
	assign head = entries[rdPtr];

	// fill saturates at the top of its range
	assign fill = count[countWidth] ? '1 : count[countWidth-1:0];

	always_ff @(posedge CLK) begin
		if (doWrite) begin
			entries[wrPtr] <= writeData;
		end
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doWrite) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			if (doWrite && !doPop) begin
				count <= count + 1'b1;
			end else if (doPop && !doWrite) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: request/requestMux.sv
`default_nettype none

module requestMux import memSwitchPkg::*; (
	input wire CLK,
	input wire RESETn,

	input wire [numChannels-1:0] LACT,
	input wire [numChannels-1:0] LCMD,
	input wire [1:0] LSIZEO [numChannels-1:0],
	input wire [addrWidth-1:0] LADDR [numChannels-1:0],
	input wire [dataWidth-1:0] LDATO [numChannels-1:0],
	input wire [localTagWidth-1:0] LTAGO [numChannels-1:0],
	output logic [numChannels-1:0] LNEXT,

	input wire FLNEXT,
	input wire SDNEXT,
	input wire IONEXT,
	output memCmd CMD,
	output logic [addrWidth-1:0] ADDR,
	output logic [dataWidth-1:0] DATA,
	output logic [beWidth-1:0] BE,
	output logic [tagWidth-1:0] TAG,
	output logic FLACT,
	output logic SDACT,
	output logic IOACT
);

	target activeTarget;
	logic busy;
	logic acceptEn;
	logic [1:0] sel;
	logic [dataWidth-1:0] dataReg;

	// selected lanes come out low
	function automatic logic [beWidth-1:0] laneEnables(input logic [2:0] low,
			input logic [1:0] size);
		logic [beWidth-1:0] lanes;
		case (size)
			2'd0: lanes = 8'h01 << low;
			2'd1: lanes = 8'h03 << {low[2:1], 1'b0};
			2'd2: lanes = 8'h0F << {low[2], 2'b00};
			default: lanes = 8'hFF;
		endcase
		return ~lanes;
	endfunction

	function automatic target regionOf(input logic [addrWidth-1:0] addr);
		if (addr < flashLimit) begin
			return targetFlash;
		end else if (addr < ioBase) begin
			return targetSdram;
		end
		return targetIo;
	endfunction

	// ----------------------------------------------------------
	// accept control
	// ----------------------------------------------------------
	assign busy = activeTarget != targetNone;
	assign FLACT = activeTarget == targetFlash;
	assign SDACT = activeTarget == targetSdram;
	assign IOACT = activeTarget == targetIo;

	// free, or the held request leaves on this edge
	assign acceptEn = ~busy | (FLACT & FLNEXT) | (SDACT & SDNEXT) | (IOACT & IONEXT);

	// lowest active channel wins
	always_comb begin
		sel = '0;
		for (int i = numChannels - 1; i >= 0; i--) begin
			if (LACT[i]) begin
				sel = 2'(i);
			end
		end
	end

	// a channel may go only while every lower one is idle
	always_comb begin
		logic clear;
		clear = acceptEn;
		for (int i = 0; i < numChannels; i++) begin
			LNEXT[i] = clear;
			clear = clear & ~LACT[i];
		end
	end

	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			activeTarget <= targetNone;
		end else if (acceptEn) begin
			activeTarget <= (|LACT) ? regionOf(LADDR[sel]) : targetNone;
		end
	end

	// ----------------------------------------------------------
	// request register
	// ----------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (acceptEn && (|LACT)) begin
			ADDR <= LADDR[sel];
			CMD <= memCmd'(LCMD[sel]);
			dataReg <= LDATO[sel];
			BE <= laneEnables(LADDR[sel][2:0], LSIZEO[sel]);
			TAG <= {LADDR[sel][2:0], LSIZEO[sel], chanIdOf(sel), LTAGO[sel]};
		end
	end

	// write data copied to every lane of its size
	always_comb begin
		case (TAG[tagSizePos +: 2])
			2'd0: DATA = {8{dataReg[7:0]}};
			2'd1: DATA = {4{dataReg[15:0]}};
			2'd2: DATA = {2{dataReg[31:0]}};
			default: DATA = dataReg;
		endcase
	end

endmodule

`default_nettype wire

// File: common/memSwitchPkg.sv
`default_nettype none

package memSwitchPkg;

	// ----------------------------------------------------------
	// bus widths
	// ----------------------------------------------------------
	localparam int addrWidth = 45;
	localparam int dataWidth = 64;
	localparam int beWidth = 8;
	localparam int localTagWidth = 13;
	localparam int tagWidth = 21;
	// queue entry is {tag, data}
	localparam int respWidth = tagWidth + dataWidth;
	localparam int queueDepth = 16;
	localparam int countWidth = 4;

	// ----------------------------------------------------------
	// address map
	// ----------------------------------------------------------
	// flash below this address
	localparam logic [addrWidth-1:0] flashLimit = 45'h000040000000;
	// sdram up to here, io from here to the top
	localparam logic [addrWidth-1:0] ioBase = 45'h1FFFFFFF0000;

	// channel ids carried in the memory tag
	localparam logic [2:0] coreId = 3'd0;
	localparam logic [2:0] streamId = 3'd2;
	localparam logic [2:0] contextId = 3'd3;
	localparam int numChannels = 3;

	// lsb positions of the tag fields
	localparam int tagLowAddrPos = 18;
	localparam int tagSizePos = 16;
	localparam int tagChanPos = 13;

	typedef enum logic {
		cmdWrite = 1'b0,
		cmdRead = 1'b1
	} memCmd;

	typedef enum logic [1:0] {
		targetNone,
		targetFlash,
		targetSdram,
		targetIo
	} target;

	// local port index to tag channel id
	function automatic logic [2:0] chanIdOf(input logic [1:0] index);
		case (index)
			2'd0: return coreId;
			2'd1: return streamId;
			default: return contextId;
		endcase
	endfunction

endpackage

`default_nettype wire
